// ==== Bender.yml ====
package:
  name: fetch_unit

sources:
  # Packages first, then the blocks, then the top level
  - files:
      - hw/rv_arch_pkg.sv
      - hw/fetch_pkg.sv
      - hw/fetch_ctrl.sv
      - hw/fetch_pc_counter.sv
      - hw/fetch_skid_buffer.sv
      - hw/fetch_unit.sv

  - target: test
    files:
      - testbench/tb_fetch_unit.sv

// ==== hw/fetch_ctrl.sv ====
`default_nettype none

module fetch_ctrl (
  input  wire logic              clk_i,
  input  wire logic              rstn_i,
  // Memory side
  input  wire logic              instr_req_ready_i,
  input  wire logic              instr_rsp_valid_i,  // Response port is always ready
  // Decoder and redirect
  input  wire logic              dec_ready_i,
  input  wire logic              redirect_i,         // Aligned jump accepted this cycle
  output logic                   instr_req_valid_o,
  output logic                   dec_valid_o,
  output logic                   req_adv_o,          // Request transfer
  output logic                   dec_adv_o,          // Decoder transfer
  output fetch_pkg::buf_op_e     buf_op_o
);

  localparam int unsigned CNT_W = $clog2(fetch_pkg::NUM_CREDITS + 1);
  localparam logic [CNT_W-1:0] MAX_CREDITS = CNT_W'(fetch_pkg::NUM_CREDITS);

  fetch_pkg::fetch_state_e state_q, state_d;
  logic [CNT_W-1:0] credits_q, credits_d;    // Free slots not yet promised to a request
  logic [CNT_W-1:0] discards_q, discards_d;  // Responses still to be swallowed
  logic [CNT_W-1:0] occupancy;
  logic [CNT_W-1:0] outstanding;             // Requests accepted, response not yet seen
  logic             rsp_keep;                // Response goes into the buffer
  logic             rsp_discard;             // Response belongs to a dropped request
  logic             req_valid_q;
  logic             dec_valid_q;

  assign req_adv_o   = req_valid_q && instr_req_ready_i;
  assign dec_adv_o   = dec_valid_q && dec_ready_i;
  assign rsp_discard = instr_rsp_valid_i && (discards_q != '0);
  assign rsp_keep    = instr_rsp_valid_i && (discards_q == '0);

  // Slots filled, from the state
  always_comb begin
    case (state_q)
      fetch_pkg::eBUSY: occupancy = CNT_W'(1);
      fetch_pkg::eFULL: occupancy = CNT_W'(2);
      default:          occupancy = '0;
    endcase
  end

  // Every credit not free is either a held instruction or an open request
  assign outstanding = MAX_CREDITS - credits_q - occupancy;

  //////////////////////////////////////////////////////////////////////
  // Buffer opcode and next state
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    buf_op_o = fetch_pkg::eHOLD;
    state_d  = state_q;
    case (state_q)
      fetch_pkg::eEMPTY: begin
        if (rsp_keep) begin   // Load
          buf_op_o = fetch_pkg::eLOAD;
          state_d  = fetch_pkg::eBUSY;
        end
      end
      fetch_pkg::eBUSY: begin
        if (rsp_keep && dec_adv_o) begin          // Flow
          buf_op_o = fetch_pkg::eFLOW;
        end else if (rsp_keep) begin              // Fill
          buf_op_o = fetch_pkg::eFILL;
          state_d  = fetch_pkg::eFULL;
        end else if (dec_adv_o) begin             // Unload, data left stale
          state_d  = fetch_pkg::eEMPTY;
        end
      end
      fetch_pkg::eFULL: begin
        if (rsp_keep && dec_adv_o) begin          // Pass
          buf_op_o = fetch_pkg::ePASS;
        end else if (dec_adv_o) begin             // Flush
          buf_op_o = fetch_pkg::eFLUSH;
          state_d  = fetch_pkg::eBUSY;
        end
        // No dump case, credits keep a third response away
      end
      default: state_d = fetch_pkg::eEMPTY;
    endcase
    if (redirect_i) begin
      buf_op_o = fetch_pkg::eDROP;
      state_d  = fetch_pkg::eEMPTY;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Credit and discard counters
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    if (redirect_i) begin
      // Everything in flight after this edge is stale
      discards_d = outstanding + CNT_W'(req_adv_o) - CNT_W'(instr_rsp_valid_i);
      credits_d  = MAX_CREDITS - discards_d;
    end else begin
      discards_d = discards_q - CNT_W'(rsp_discard);
      credits_d  = credits_q - CNT_W'(req_adv_o) + CNT_W'(dec_adv_o)
                   + CNT_W'(rsp_discard);
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      state_q     <= fetch_pkg::eEMPTY;
      credits_q   <= MAX_CREDITS;
      discards_q  <= '0;
      req_valid_q <= 1'b0;
      dec_valid_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      credits_q   <= credits_d;
      discards_q  <= discards_d;
      req_valid_q <= (credits_d != '0) && (discards_d == '0);  // Stall while draining
      dec_valid_q <= (state_d != fetch_pkg::eEMPTY);
    end
  end

  assign instr_req_valid_o = req_valid_q;
  assign dec_valid_o       = dec_valid_q;

endmodule : fetch_ctrl

`default_nettype wire

// ==== hw/fetch_pc_counter.sv ====
`default_nettype none

module fetch_pc_counter #(
  parameter rv_arch_pkg::word_t BOOT_ADDR = rv_arch_pkg::RESET_VECTOR
) (
  input  wire logic                clk_i,
  input  wire logic                rstn_i,
  input  wire logic                jmp_valid_i,
  input  wire rv_arch_pkg::word_t  jmp_addr_i,
  input  wire logic                req_adv_i,        // Request accepted by memory
  input  wire logic                dec_adv_i,        // Instruction taken by decoder
  output rv_arch_pkg::word_t       instr_req_addr_o,
  output rv_arch_pkg::word_t       dec_pc_o,
  output logic                     redirect_o,       // Aligned jump, same cycle
  output logic                     exception_o,      // Misaligned target, one cycle
  output rv_arch_pkg::word_t       fault_addr_o
);

  localparam int unsigned ALIGN_BITS = $clog2(rv_arch_pkg::INSTR_BYTES);
  localparam rv_arch_pkg::word_t PC_STEP = rv_arch_pkg::word_t'(rv_arch_pkg::INSTR_BYTES);

  rv_arch_pkg::word_t req_pc_q;
  rv_arch_pkg::word_t dec_pc_q;
  logic               jmp_aligned;
  logic               exc_q;
  rv_arch_pkg::word_t fault_q;

  assign jmp_aligned = (jmp_addr_i[ALIGN_BITS-1:0] == '0);
  assign redirect_o  = jmp_valid_i && jmp_aligned;

  //////////////////////////////////////////////////////////////////////
  // PC registers
  //////////////////////////////////////////////////////////////////////
  // Redirect wins over a request fired in the same cycle
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      req_pc_q <= BOOT_ADDR;
    end else if (redirect_o) begin
      req_pc_q <= jmp_addr_i;
    end else if (req_adv_i) begin
      req_pc_q <= req_pc_q + PC_STEP;
    end
  end

  // PC of the instruction on the decoder port
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      dec_pc_q <= BOOT_ADDR;
    end else if (redirect_o) begin
      dec_pc_q <= jmp_addr_i;
    end else if (dec_adv_i) begin
      dec_pc_q <= dec_pc_q + PC_STEP;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Misaligned jump exception
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      exc_q <= 1'b0;
    end else begin
      exc_q <= jmp_valid_i && !jmp_aligned;  // Jump is ignored otherwise
    end
  end

  // Held until the next bad target
  always_ff @(posedge clk_i) begin
    if (jmp_valid_i && !jmp_aligned) fault_q <= jmp_addr_i;
  end

  assign instr_req_addr_o = req_pc_q;
  assign dec_pc_o         = dec_pc_q;
  assign exception_o      = exc_q;
  assign fault_addr_o     = fault_q;

endmodule : fetch_pc_counter

`default_nettype wire

// ==== hw/fetch_pkg.sv ====
`default_nettype none

// Fetch-stage definitions
package fetch_pkg;

  // Buffer occupancy, one state per filled slot count
  typedef enum logic [1:0] {
    eEMPTY, // Nothing held
    eBUSY,  // Output register valid
    eFULL   // Output and skid register valid
  } fetch_state_e;

  // Operations for the skid buffer
  typedef enum logic [2:0] {
    eHOLD,  // No change
    eLOAD,  // Response into output reg
    eFILL,  // Response into skid reg
    eFLOW,  // Response replaces output reg
    eFLUSH, // Skid reg into output reg
    ePASS,  // Skid to output, response to skid
    eDROP   // Redirect, clear both
  } buf_op_e;

  // Buffer depth, also the number of request credits
  localparam int unsigned NUM_CREDITS = 2;

endpackage : fetch_pkg

`default_nettype wire

// ==== hw/fetch_skid_buffer.sv ====
`default_nettype none

module fetch_skid_buffer (
  input  wire logic                clk_i,
  input  wire logic                rstn_i,
  input  wire fetch_pkg::buf_op_e  buf_op_i,
  input  wire rv_arch_pkg::word_t  rsp_data_i,
  input  wire logic                rsp_error_i,
  output rv_arch_pkg::word_t       dec_instr_o,
  output logic                     dec_error_o
);

  rv_arch_pkg::word_t out_data_q, skid_data_q;
  logic               out_err_q, skid_err_q;
  logic               out_en;     // Output register write
  logic               skid_en;    // Skid register write
  logic               use_skid;   // Output takes skid instead of response
  logic               drop;
  rv_arch_pkg::word_t sel_data;
  logic               sel_err;

  //////////////////////////////////////////////////////////////////////
  // Opcode decode
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    out_en   = 1'b0;
    skid_en  = 1'b0;
    use_skid = 1'b0;
    drop     = 1'b0;
    case (buf_op_i)
      fetch_pkg::eLOAD,
      fetch_pkg::eFLOW:  out_en = 1'b1;
      fetch_pkg::eFILL:  skid_en = 1'b1;
      fetch_pkg::eFLUSH: begin
        out_en   = 1'b1;
        use_skid = 1'b1;
      end
      fetch_pkg::ePASS: begin  // Both move at once
        out_en   = 1'b1;
        skid_en  = 1'b1;
        use_skid = 1'b1;
      end
      fetch_pkg::eDROP:  drop = 1'b1;
      default: ;               // Hold
    endcase
  end

  assign sel_data = use_skid ? skid_data_q : rsp_data_i;
  assign sel_err  = use_skid ? skid_err_q  : rsp_error_i;

  // Instruction words
  always_ff @(posedge clk_i) begin
    if (out_en)  out_data_q  <= sel_data;
    if (skid_en) skid_data_q <= rsp_data_i;
  end

  // Error flags, cleared on reset and redirect
  always_ff @(posedge clk_i) begin
    if (!rstn_i || drop) begin
      out_err_q  <= 1'b0;
      skid_err_q <= 1'b0;
    end else begin
      if (out_en)  out_err_q  <= sel_err;
      if (skid_en) skid_err_q <= rsp_error_i;
    end
  end

  assign dec_instr_o = out_data_q;
  assign dec_error_o = out_err_q;

endmodule : fetch_skid_buffer

`default_nettype wire

// ==== hw/fetch_unit.sv ====
`default_nettype none

module fetch_unit #(
  parameter rv_arch_pkg::word_t BOOT_ADDR = rv_arch_pkg::RESET_VECTOR
) (
  input  wire logic                clk_i,
  input  wire logic                rstn_i,
  // Instruction memory request
  output logic                     instr_req_valid_o,
  output rv_arch_pkg::word_t       instr_req_addr_o,
  input  wire logic                instr_req_ready_i,
  // Instruction memory response, in order
  input  wire logic                instr_rsp_valid_i,
  input  wire rv_arch_pkg::word_t  instr_rsp_data_i,
  input  wire logic                instr_rsp_error_i,
  output logic                     instr_rsp_ready_o,
  // Decoder
  output logic                     dec_valid_o,
  output rv_arch_pkg::word_t       dec_instr_o,
  output rv_arch_pkg::word_t       dec_pc_o,
  output logic                     dec_error_o,   // Bus error on this fetch
  input  wire logic                dec_ready_i,
  // Redirect from later stages
  input  wire logic                jmp_valid_i,
  input  wire rv_arch_pkg::word_t  jmp_addr_i,
  output logic                     exception_o,   // Misaligned jump target
  output rv_arch_pkg::word_t       fault_addr_o
);

  logic               redirect;
  logic               req_adv;
  logic               dec_adv;
  fetch_pkg::buf_op_e buf_op;

  // Credits guarantee room for every response
  assign instr_rsp_ready_o = 1'b1;

  //////////////////////////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////////////////////////
  fetch_ctrl ctrl_i (
    .clk_i             (clk_i),
    .rstn_i            (rstn_i),
    .instr_req_ready_i (instr_req_ready_i),
    .instr_rsp_valid_i (instr_rsp_valid_i),
    .dec_ready_i       (dec_ready_i),
    .redirect_i        (redirect),
    .instr_req_valid_o (instr_req_valid_o),
    .dec_valid_o       (dec_valid_o),
    .req_adv_o         (req_adv),
    .dec_adv_o         (dec_adv),
    .buf_op_o          (buf_op)
  );

  // Request and decode PCs
  fetch_pc_counter #(
    .BOOT_ADDR (BOOT_ADDR)
  ) pc_i (
    .clk_i            (clk_i),
    .rstn_i           (rstn_i),
    .jmp_valid_i      (jmp_valid_i),
    .jmp_addr_i       (jmp_addr_i),
    .req_adv_i        (req_adv),
    .dec_adv_i        (dec_adv),
    .instr_req_addr_o (instr_req_addr_o),
    .dec_pc_o         (dec_pc_o),
    .redirect_o       (redirect),
    .exception_o      (exception_o),
    .fault_addr_o     (fault_addr_o)
  );

  // Two-entry instruction buffer
  fetch_skid_buffer buf_i (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .buf_op_i    (buf_op),
    .rsp_data_i  (instr_rsp_data_i),
    .rsp_error_i (instr_rsp_error_i),
    .dec_instr_o (dec_instr_o),
    .dec_error_o (dec_error_o)
  );

endmodule : fetch_unit

`default_nettype wire

// ==== hw/rv_arch_pkg.sv ====
`default_nettype none

// Architecture-level definitions of the RV32 core
package rv_arch_pkg;

  // Data and address width
  localparam int unsigned XLEN = 32;

  // One instruction or address word
  typedef logic [XLEN-1:0] word_t;

  // No compressed instructions, so every fetch is a full word
  localparam int unsigned INSTR_BYTES = 4;

  // Default boot address
  localparam word_t RESET_VECTOR = 32'h8000_0000;

endpackage : rv_arch_pkg

`default_nettype wire

// ==== project.f ====
hw/rv_arch_pkg.sv
hw/fetch_pkg.sv
hw/fetch_ctrl.sv
hw/fetch_pc_counter.sv
hw/fetch_skid_buffer.sv
hw/fetch_unit.sv
testbench/tb_fetch_unit.sv

// ==== testbench/tb_fetch_unit.sv ====
`default_nettype none

module tb_fetch_unit;
  timeunit 1ns;
  timeprecision 100ps;

  localparam rv_arch_pkg::word_t BOOT_ADDR = rv_arch_pkg::RESET_VECTOR;
  localparam int CLK_PERIOD = 4;
  localparam int N_SEQ   = 40;
  localparam int N_STALL = 60;
  localparam int N_BP    = 80;
  localparam int N_JMP   = 4 * 10;  // Four jumps
  localparam int N_MIS   = 4 * 6;   // Four bad targets
  localparam int N_ERR   = 16;
  // Up to 8 cycles per transfer, plus reset
  localparam int TEST_CYCLES = (N_SEQ + N_STALL + N_BP + N_JMP + N_MIS + N_ERR) * 8 + 16;
  localparam int TIMEOUT_NS  = TEST_CYCLES * CLK_PERIOD * 4;
  localparam rv_arch_pkg::word_t ERR_LO = 32'h8000_0100;  // Bus error window
  localparam rv_arch_pkg::word_t ERR_HI = 32'h8000_010f;

  logic               clk_i;
  logic               rstn_i;
  logic               instr_req_valid_o, instr_req_ready_i;
  rv_arch_pkg::word_t instr_req_addr_o;
  logic               instr_rsp_valid_i, instr_rsp_error_i, instr_rsp_ready_o;
  rv_arch_pkg::word_t instr_rsp_data_i;
  logic               dec_valid_o, dec_error_o, dec_ready_i;
  rv_arch_pkg::word_t dec_instr_o, dec_pc_o;
  logic               jmp_valid_i, exception_o;
  rv_arch_pkg::word_t jmp_addr_i, fault_addr_o;

  logic [31:0]        rng_state = 32'h516b_50ea;
  logic               mem_rand, dec_rand, lat_rand;  // Randomize ready, dec ready, latency
  int                 cycle;
  rv_arch_pkg::word_t addr_q[$];                      // Accepted, not yet answered
  int                 due_q[$];                       // Edge where each response is taken
  int                 check_cnt, err_cnt;
  int                 xfer_cnt, err_seen, exc_seen;   // Written with NBAs only
  int                 test_xfer_base, test_err_base;
  rv_arch_pkg::word_t pc_expected, req_expected, fault_expected;
  rv_arch_pkg::word_t held_pc, held_instr;
  logic               exc_expected, stalled, held_err;
  int                 pending;                        // Requests minus transfers since last jump

  fetch_unit #(
    .BOOT_ADDR (BOOT_ADDR)
  ) dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;  // LCG step
    return rng_state;
  endfunction

  // Upper half inverted, so a stale word never matches a new PC
  function automatic rv_arch_pkg::word_t mem_word(input rv_arch_pkg::word_t addr);
    return {~addr[31:16], addr[15:0]};
  endfunction

  function automatic logic bus_error_at(input rv_arch_pkg::word_t addr);
    return (addr >= ERR_LO) && (addr <= ERR_HI);
  endfunction

  task automatic check_word(input string name, input rv_arch_pkg::word_t got,
                            input rv_arch_pkg::word_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("error %s: got %h, expected %h at %0t ns", name, got, exp, $time);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("error %s: got %h, expected %h at %0t ns", name, got, exp, $time);
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    check_cnt++;
    if (got != exp) begin
      err_cnt++;
      $display("%s: saw %0d, expected %0d", what, got, exp);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Memory and decoder models
  //////////////////////////////////////////////////////////////////////
  always @(posedge clk_i) begin : memory_model
    logic [31:0]        r;
    int                 due;
    rv_arch_pkg::word_t a;
    r = next_rand();  // Only random source, fixed call order
    if (!rstn_i) begin
      addr_q.delete();
      due_q.delete();
      instr_req_ready_i <= 1'b0;
      instr_rsp_valid_i <= 1'b0;
      dec_ready_i       <= 1'b0;
    end else begin
      if (instr_req_valid_o && instr_req_ready_i) begin
        due = cycle + (lat_rand ? 1 + int'(r[9:8]) % 3 : 1);
        if (due_q.size() > 0 && due <= due_q[$]) due = due_q[$] + 1;  // Keep order
        addr_q.push_back(instr_req_addr_o);
        due_q.push_back(due);
      end
      if (due_q.size() > 0 && due_q[0] <= cycle + 1) begin
        a = addr_q.pop_front();
        void'(due_q.pop_front());
        instr_rsp_valid_i <= 1'b1;
        instr_rsp_data_i  <= mem_word(a);
        instr_rsp_error_i <= bus_error_at(a);
      end else begin
        instr_rsp_valid_i <= 1'b0;
      end
      instr_req_ready_i <= mem_rand ? (r[17:16] != 2'b00) : 1'b1;  // 3 in 4
      dec_ready_i       <= dec_rand ? r[24] : 1'b1;
    end
    cycle = cycle + 1;
  end

  //////////////////////////////////////////////////////////////////////
  // Scoreboard
  //////////////////////////////////////////////////////////////////////
  always @(posedge clk_i) begin : compare
    logic acc, xfer, jmp_ok, jmp_bad;
    if (rstn_i) begin
      acc     = instr_req_valid_o && instr_req_ready_i;
      xfer    = dec_valid_o && dec_ready_i;
      jmp_ok  = jmp_valid_i && (jmp_addr_i[1:0] == 2'b00);
      jmp_bad = jmp_valid_i && (jmp_addr_i[1:0] != 2'b00);
      check_bit("instr_rsp_ready_o", instr_rsp_ready_o, 1'b1);
      check_bit("exception_o", exception_o, exc_expected);  // One cycle after bad jump
      // Fault address held from the first bad target on
      if (exc_expected || exc_seen > 0) begin
        check_word("fault_addr_o", fault_addr_o, fault_expected);
      end
      exc_expected = jmp_bad;
      if (jmp_bad) fault_expected = jmp_addr_i;
      if (exception_o) exc_seen <= exc_seen + 1;
      if (stalled) begin  // Stalled outputs must not move
        check_bit("dec_valid_o", dec_valid_o, 1'b1);
        check_word("dec_pc_o", dec_pc_o, held_pc);
        check_word("dec_instr_o", dec_instr_o, held_instr);
        check_bit("dec_error_o", dec_error_o, held_err);
      end
      stalled    = dec_valid_o && !dec_ready_i && !jmp_ok;
      held_pc    = dec_pc_o;
      held_instr = dec_instr_o;
      held_err   = dec_error_o;
      if (acc) begin
        check_word("instr_req_addr_o", instr_req_addr_o, req_expected);
        req_expected = req_expected + rv_arch_pkg::INSTR_BYTES;
      end
      if (xfer) begin
        check_word("dec_pc_o", dec_pc_o, pc_expected);
        check_word("dec_instr_o", dec_instr_o, mem_word(pc_expected));
        check_bit("dec_error_o", dec_error_o, bus_error_at(pc_expected));
        pc_expected = pc_expected + rv_arch_pkg::INSTR_BYTES;
        xfer_cnt <= xfer_cnt + 1;
        if (dec_error_o) err_seen <= err_seen + 1;
      end
      pending = pending + int'(acc) - int'(xfer);
      check_cnt++;
      if (pending > fetch_pkg::NUM_CREDITS) begin
        err_cnt++;
        $display("%0d requests outstanding at %0t ns, more than the buffer holds",
                 pending, $time);
      end
      if (jmp_ok) begin  // Both PCs restart at the target
        req_expected = jmp_addr_i;
        pc_expected  = jmp_addr_i;
        pending      = 0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////
  task automatic set_mode(input logic mem_r, input logic dec_r, input logic lat_r);
    mem_rand <= mem_r;
    dec_rand <= dec_r;
    lat_rand <= lat_r;
  endtask

  task automatic wait_transfers(input int n);
    int target;
    target = xfer_cnt + n;
    while (xfer_cnt < target) @(posedge clk_i);
  endtask

  task automatic jump_to(input rv_arch_pkg::word_t addr);
    @(posedge clk_i);
    jmp_valid_i <= 1'b1;  // One-cycle pulse
    jmp_addr_i  <= addr;
    @(posedge clk_i);
    jmp_valid_i <= 1'b0;
  endtask

  task automatic start_test();
    test_xfer_base = xfer_cnt;
    test_err_base  = err_cnt;
  endtask

  task automatic finish_test(input string name);
    fetch_pkg::fetch_state_e st;
    st = dut_i.ctrl_i.state_q;
    $display("test %s: %0d transfers, %0d errors, buffer %s", name,
             xfer_cnt - test_xfer_base, err_cnt - test_err_base, st.name());
  endtask

  initial begin : main
    int base;
    int k;
    rstn_i            = 1'b0;
    instr_req_ready_i = 1'b0;
    instr_rsp_valid_i = 1'b0;
    instr_rsp_data_i  = '0;
    instr_rsp_error_i = 1'b0;
    dec_ready_i       = 1'b0;
    jmp_valid_i       = 1'b0;
    jmp_addr_i        = '0;
    {mem_rand, dec_rand, lat_rand} = 3'b000;
    pc_expected  = BOOT_ADDR;
    req_expected = BOOT_ADDR;
    exc_expected = 1'b0;
    stalled      = 1'b0;
    pending      = 0;
    repeat (2) @(posedge clk_i);
    check_bit("instr_req_valid_o", instr_req_valid_o, 1'b0);
    check_bit("dec_valid_o", dec_valid_o, 1'b0);
    check_bit("exception_o", exception_o, 1'b0);
    check_word("instr_req_addr_o", instr_req_addr_o, BOOT_ADDR);
    check_word("dec_pc_o", dec_pc_o, BOOT_ADDR);
    rstn_i <= 1'b1;
    repeat (2) @(posedge clk_i);
    check_bit("instr_req_valid_o", instr_req_valid_o, 1'b1);  // First cycle out of reset

    start_test();
    wait_transfers(N_SEQ);
    finish_test("sequential fetch");
    start_test();
    set_mode(1'b0, 1'b1, 1'b0);
    wait_transfers(N_STALL);
    finish_test("decoder stalls");
    start_test();
    set_mode(1'b1, 1'b1, 1'b1);
    wait_transfers(N_BP);
    finish_test("memory back-pressure");

    start_test();
    for (k = 0; k < 4; k++) begin
      jump_to(32'h8000_0800 + k * 64);
      wait_transfers(N_JMP / 4);
    end
    finish_test("aligned jump");
    start_test();
    base = exc_seen;
    for (k = 0; k < 4; k++) begin
      jump_to(32'h8000_0400 + k * 32 + (k % 3) + 1);  // Low bits 1, 2, 3
      wait_transfers(N_MIS / 4);
    end
    check_count("misaligned jump exceptions", exc_seen - base, 4);
    finish_test("misaligned jump");
    start_test();
    base = err_seen;
    jump_to(32'h8000_00f0);  // Runs through the whole window
    wait_transfers(N_ERR);
    check_count("words flagged in the error window", err_seen - base, 4);
    finish_test("bus error");

    $display("%0d checks, %0d errors", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("timeout after %0d ns, the decoder stopped receiving instructions", TIMEOUT_NS);
    $display("Testbench failed");
    $finish;
  end

endmodule : tb_fetch_unit

`default_nettype wire
